/* source/red_pkg.sv */
////////////////////
// Shared widths, opcodes and payload structs for the narrow offload
// reduction unit. Modules refer to them by scoped name.
////////////////////

package red_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Narrow operand width
  localparam int unsigned DataWidth = 32;

  // Parallel reduction lanes, rotated by dispatcher and collector
  localparam int unsigned NumLanes = 4;

  // Lane pointer width, must cover NumLanes
  localparam int unsigned LaneIdxWidth = 2;

  ////////////////////
  // Operation codes
  ////////////////////

  // Reduction operation as seen on the request port
  // Codes 4 to 7 are unknown and reduce to zero
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_MUL = 3'd1,
    OP_MAX = 3'd2,
    OP_MIN = 3'd3
  } reduction_op_e;

  // Lane internal opcode after decode
  typedef enum logic [1:0] {
    ALU_NONE   = 2'd0,
    ALU_ADD    = 2'd1,
    ALU_MUL    = 2'd2,
    ALU_MINMAX = 2'd3
  } alu_op_e;

  ////////////////////
  // Payloads
  ////////////////////

  typedef logic [DataWidth-1:0] data_t;

  // Request beat
  typedef struct packed {
    reduction_op_e op;
    data_t         operand_a;
    data_t         operand_b;
  } red_req_t;

  // Response beat
  typedef struct packed {
    data_t result;
  } red_rsp_t;

endpackage

/* source/red_dispatch.sv */
////////////////////
// Request dispatcher. Steers each accepted request to the lane whose
// turn it is, so lanes fill in strict rotation.
////////////////////

module red_dispatch (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Request port
  input  red_pkg::red_req_t                  req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  // Lane side
  output red_pkg::red_req_t                  lane_req_o,
  output logic [red_pkg::NumLanes-1:0]       lane_valid_o,
  input  logic [red_pkg::NumLanes-1:0]       lane_ready_i
);

  localparam logic [red_pkg::LaneIdxWidth-1:0] LastLane =
    red_pkg::LaneIdxWidth'(red_pkg::NumLanes - 1);

  logic [red_pkg::LaneIdxWidth-1:0] turn_q;
  logic                             req_fire;

  ////////////////////
  // Lane steering
  ////////////////////

  // Payload goes to every lane, only one sees valid
  assign lane_req_o = req_i;

  always_comb begin
    lane_valid_o = '0;
    for (int unsigned i = 0; i < red_pkg::NumLanes; i++) begin
      if (turn_q == red_pkg::LaneIdxWidth'(i)) begin
        lane_valid_o[i] = req_valid_i;
      end
    end
  end

  // Ready comes from the current lane only
  assign req_ready_o = lane_ready_i[turn_q];

  assign req_fire = req_valid_i && req_ready_o;

  ////////////////////
  // Turn pointer
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      turn_q <= '0;
    end else if (req_fire) begin
      if (turn_q == LastLane) begin
        turn_q <= '0;
      end else begin
        turn_q <= turn_q + 1'b1;
      end
    end
  end

endmodule

/* source/red_lane.sv */
////////////////////
// One reduction lane. Decodes the operation, computes the narrow
// result and holds it in a one-entry output register.
// Latency from request transfer to response valid is one cycle.
////////////////////

module red_lane (
  input  logic              clk_i,
  input  logic              rst_i,
  // Request from dispatcher
  input  red_pkg::red_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  // Response to collector
  output red_pkg::red_rsp_t rsp_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i
);

  red_pkg::alu_op_e          alu_op;
  logic                      sel_max;
  red_pkg::data_t [2:0]      operands;
  logic                      a_gt_b;
  red_pkg::data_t            product;
  red_pkg::data_t            result;

  ////////////////////
  // Operation decode
  ////////////////////

  always_comb begin
    alu_op   = red_pkg::ALU_NONE;
    sel_max  = 1'b0;
    operands = '0;
    case (req_i.op)
      red_pkg::OP_ADD: begin
        // Zero in slot 0, addends in slots 1 and 2
        alu_op      = red_pkg::ALU_ADD;
        operands[0] = '0;
        operands[1] = req_i.operand_a;
        operands[2] = req_i.operand_b;
      end
      red_pkg::OP_MUL: begin
        alu_op      = red_pkg::ALU_MUL;
        operands[0] = req_i.operand_a;
        operands[1] = req_i.operand_b;
      end
      red_pkg::OP_MAX: begin
        alu_op      = red_pkg::ALU_MINMAX;
        sel_max     = 1'b1;
        operands[0] = req_i.operand_a;
        operands[1] = req_i.operand_b;
      end
      red_pkg::OP_MIN: begin
        alu_op      = red_pkg::ALU_MINMAX;
        sel_max     = 1'b0;
        operands[0] = req_i.operand_a;
        operands[1] = req_i.operand_b;
      end
      default: begin
        // Unknown code, zero operands
        alu_op   = red_pkg::ALU_NONE;
        operands = '0;
      end
    endcase
  end

  ////////////////////
  // Compute
  ////////////////////

  assign a_gt_b = $signed(operands[0]) > $signed(operands[1]);

  // Low word of the product only
  assign product = operands[0] * operands[1];

  always_comb begin
    case (alu_op)
      red_pkg::ALU_ADD:    result = operands[1] + operands[2];
      red_pkg::ALU_MUL:    result = product;
      // Max keeps a when a > b, min keeps a otherwise
      red_pkg::ALU_MINMAX: result = (sel_max == a_gt_b) ? operands[0] : operands[1];
      default:             result = '0;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////

  // Free when empty or drained this cycle
  assign req_ready_o = !rsp_valid_o || rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      rsp_o.result <= result;
    end
  end

endmodule

/* source/red_collect.sv */
////////////////////
// Response collector. Drains the lanes in the same rotation the
// dispatcher fills them, so results leave in request order.
////////////////////

module red_collect (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  // Lane side
  input  red_pkg::red_rsp_t [red_pkg::NumLanes-1:0]   lane_rsp_i,
  input  logic              [red_pkg::NumLanes-1:0]   lane_rsp_valid_i,
  output logic              [red_pkg::NumLanes-1:0]   lane_rsp_ready_o,
  // Response port
  output red_pkg::red_rsp_t                           rsp_o,
  output logic                                        rsp_valid_o,
  input  logic                                        rsp_ready_i
);

  localparam logic [red_pkg::LaneIdxWidth-1:0] LastLane =
    red_pkg::LaneIdxWidth'(red_pkg::NumLanes - 1);

  logic [red_pkg::LaneIdxWidth-1:0] turn_q;
  logic                             rsp_fire;

  ////////////////////
  // Lane select
  ////////////////////

  assign rsp_o       = lane_rsp_i[turn_q];
  assign rsp_valid_o = lane_rsp_valid_i[turn_q];

  // Ready granted to the current lane only
  always_comb begin
    lane_rsp_ready_o = '0;
    for (int unsigned i = 0; i < red_pkg::NumLanes; i++) begin
      if (turn_q == red_pkg::LaneIdxWidth'(i)) begin
        lane_rsp_ready_o[i] = rsp_ready_i;
      end
    end
  end

  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  ////////////////////
  // Turn pointer
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      turn_q <= '0;
    end else if (rsp_fire) begin
      if (turn_q == LastLane) begin
        turn_q <= '0;
      end else begin
        turn_q <= turn_q + 1'b1;
      end
    end
  end

endmodule

/* source/red_offload_unit.sv */
////////////////////
// Narrow offload reduction unit, top level. Valid/ready on request and
// response ports, NumLanes lanes in flight, results in request order.
////////////////////

module red_offload_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  // Request port
  input  red_pkg::red_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  // Response port
  output red_pkg::red_rsp_t rsp_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i
);

  // Dispatcher to lanes
  red_pkg::red_req_t                        lane_req;
  logic              [red_pkg::NumLanes-1:0] lane_valid;
  logic              [red_pkg::NumLanes-1:0] lane_ready;

  // Lanes to collector
  red_pkg::red_rsp_t [red_pkg::NumLanes-1:0] lane_rsp;
  logic              [red_pkg::NumLanes-1:0] lane_rsp_valid;
  logic              [red_pkg::NumLanes-1:0] lane_rsp_ready;

  ////////////////////
  // Dispatcher
  ////////////////////

  red_dispatch u_dispatch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .lane_req_o   (lane_req),
    .lane_valid_o (lane_valid),
    .lane_ready_i (lane_ready)
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar i = 0; i < red_pkg::NumLanes; i++) begin : gen_lanes
    red_lane u_lane (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (lane_req),
      .req_valid_i (lane_valid[i]),
      .req_ready_o (lane_ready[i]),
      .rsp_o       (lane_rsp[i]),
      .rsp_valid_o (lane_rsp_valid[i]),
      .rsp_ready_i (lane_rsp_ready[i])
    );
  end

  ////////////////////
  // Collector
  ////////////////////

  red_collect u_collect (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lane_rsp_i       (lane_rsp),
    .lane_rsp_valid_i (lane_rsp_valid),
    .lane_rsp_ready_o (lane_rsp_ready),
    .rsp_o            (rsp_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i)
  );

endmodule

/* verif/red_offload_sva.sv */
////////////////////
// Handshake assertions for the offload reduction unit, bound to the
// top level.
////////////////////

module red_offload_sva (
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_ready_o,
  input red_pkg::red_rsp_t rsp_o,
  input logic              rsp_valid_o,
  input logic              rsp_ready_i
);

  // Stalled response keeps valid and payload
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("response valid dropped or payload changed while stalled");

  // Unit comes out of reset empty
  assert property (@(posedge clk_i) rst_i |=> !rsp_valid_o)
    else $error("response valid high in the cycle after reset");

  assert property (@(posedge clk_i) rst_i |=> req_ready_o)
    else $error("request ready low in the cycle after reset");

endmodule

bind red_offload_unit red_offload_sva u_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_ready_o (req_ready_o),
  .rsp_o       (rsp_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i)
);

/* verif/red_tb_clk.sv */
////////////////////
// Testbench clock and reset source. Period of 40 time units, reset
// held high over the first two rising edges.
////////////////////

module red_tb_clk (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* verif/red_tb.sv */
////////////////////
// Testbench for the offload reduction unit. Directed tests push
// requests through a cycle stepper and compare every response with
// a reference model, in request order.
////////////////////

module red_tb;

  localparam int unsigned ClkPeriod     = 40;
  localparam int unsigned NumOpChecks   = 8;
  localparam int unsigned NumUnknown    = 4;
  localparam int unsigned NumStalled    = red_pkg::NumLanes + 1;
  localparam int unsigned NumRandom     = 200;
  localparam int unsigned TotalRequests = NumOpChecks + NumUnknown + NumStalled + NumRandom;
  // Random ready stalls cost extra cycles per request
  localparam int unsigned TimeoutCycles = 3 * TotalRequests + 100;

  logic              clk_i;
  logic              rst_i;
  red_pkg::red_req_t req_i;
  logic              req_valid_i;
  logic              req_ready_o;
  red_pkg::red_rsp_t rsp_o;
  logic              rsp_valid_o;
  logic              rsp_ready_i;

  red_pkg::red_req_t req_q[$];
  red_pkg::red_rsp_t exp_q[$];
  int unsigned       n_accepted;
  int unsigned       n_responses;
  integer            seed;

  red_tb_clk u_clk (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  red_offload_unit u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_rsp(input red_pkg::red_rsp_t got, input red_pkg::red_rsp_t exp);
    if (got !== exp) begin
      $display("error: rsp_o.result got %h expected %h", got.result, exp.result);
      stop_with_failure();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Reference model with wrap for add and mul and signed compare for max and min
  function automatic red_pkg::red_rsp_t model_result(input red_pkg::red_req_t req);
    red_pkg::red_rsp_t  rsp;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic        [63:0] prod;
    sa   = req.operand_a;
    sb   = req.operand_b;
    prod = 64'(req.operand_a) * 64'(req.operand_b);
    case (req.op)
      red_pkg::OP_ADD: rsp.result = req.operand_a + req.operand_b;
      red_pkg::OP_MUL: rsp.result = prod[31:0];
      red_pkg::OP_MAX: rsp.result = (sa > sb) ? req.operand_a : req.operand_b;
      red_pkg::OP_MIN: rsp.result = (sa < sb) ? req.operand_a : req.operand_b;
      default:         rsp.result = '0;
    endcase
    return rsp;
  endfunction

  function automatic red_pkg::red_req_t make_req(input red_pkg::reduction_op_e op,
                                                 input red_pkg::data_t a,
                                                 input red_pkg::data_t b);
    red_pkg::red_req_t req;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  function automatic red_pkg::red_req_t random_req();
    logic [2:0] op_bits;
    op_bits = 3'($random(seed));
    return make_req(red_pkg::reduction_op_e'(op_bits), red_pkg::data_t'($random(seed)),
                    red_pkg::data_t'($random(seed)));
  endfunction

  // Drive at the rising edge and observe at the falling edge
  task automatic step(input logic ready);
    red_pkg::red_rsp_t exp_rsp;
    @(posedge clk_i);
    if (req_q.size() > 0) begin
      req_valid_i <= 1'b1;
      req_i       <= req_q[0];
    end else begin
      req_valid_i <= 1'b0;
    end
    rsp_ready_i <= ready;
    @(negedge clk_i);
    // Responses first since a request accepted now answers later
    if (rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("a response appeared with no request outstanding");
        stop_with_failure();
      end else begin
        exp_rsp = exp_q.pop_front();
        check_rsp(rsp_o, exp_rsp);
        n_responses++;
      end
    end
    if (req_valid_i && req_ready_o) begin
      exp_q.push_back(model_result(req_q.pop_front()));
      n_accepted++;
    end
  endtask

  task automatic run_until_empty(input logic random_ready);
    while (req_q.size() > 0 || exp_q.size() > 0) begin
      if (random_ready) begin
        step(1'($random(seed)));
      end else begin
        step(1'b1);
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_state();
    wait (rst_i === 1'b0);
    @(negedge clk_i);
    check_ready("rsp_valid_o", rsp_valid_o, 1'b0);
    check_ready("req_ready_o", req_ready_o, 1'b1);
  endtask

  // Response valid must follow acceptance by exactly one cycle
  task automatic single_op_latency(input red_pkg::red_req_t req);
    req_q.push_back(req);
    step(1'b1);
    check_ready("req_ready_o", req_ready_o, 1'b1);
    check_ready("rsp_valid_o", rsp_valid_o, 1'b0);
    step(1'b1);
    check_ready("rsp_valid_o", rsp_valid_o, 1'b1);
  endtask

  task automatic each_operation();
    single_op_latency(make_req(red_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0002));
    single_op_latency(make_req(red_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001));
    single_op_latency(make_req(red_pkg::OP_MUL, 32'h0001_0000, 32'h0001_0000));
    single_op_latency(make_req(red_pkg::OP_MUL, 32'hffff_fffe, 32'h0000_0003));
    single_op_latency(make_req(red_pkg::OP_MAX, 32'hffff_fffb, 32'h0000_0003));
    single_op_latency(make_req(red_pkg::OP_MAX, 32'h8000_0000, 32'h7fff_ffff));
    single_op_latency(make_req(red_pkg::OP_MIN, 32'hffff_fffb, 32'h0000_0003));
    single_op_latency(make_req(red_pkg::OP_MIN, 32'hffff_ffff, 32'hffff_fffe));
  endtask

  task automatic unknown_codes();
    for (int code = 4; code < 8; code++) begin
      single_op_latency(make_req(red_pkg::reduction_op_e'(3'(code)),
                                 red_pkg::data_t'($random(seed)),
                                 red_pkg::data_t'($random(seed))));
    end
  endtask

  task automatic backpressure_drain();
    int unsigned start;
    start = n_accepted;
    for (int k = 0; k < NumStalled; k++) begin
      req_q.push_back(random_req());
    end
    repeat (NumStalled + 3) step(1'b0);
    if (n_accepted - start != red_pkg::NumLanes) begin
      $display("error: accepted requests got %h expected %h", n_accepted - start,
               red_pkg::NumLanes);
      stop_with_failure();
    end
    check_ready("req_ready_o", req_ready_o, 1'b0);
    check_ready("rsp_valid_o", rsp_valid_o, 1'b1);
    run_until_empty(1'b0);
  endtask

  task automatic random_traffic();
    for (int k = 0; k < NumRandom; k++) begin
      req_q.push_back(random_req());
    end
    run_until_empty(1'b1);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed        = 42;
    n_accepted  = 0;
    n_responses = 0;
    req_i       <= '0;
    req_valid_i <= 1'b0;
    rsp_ready_i <= 1'b0;
    reset_state();
    each_operation();
    unknown_codes();
    backpressure_drain();
    random_traffic();
    if (n_accepted == TotalRequests && n_responses == TotalRequests) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("request or response count differs from the number sent");
      stop_with_failure();
    end
  end

  initial begin : watchdog
    #(TimeoutCycles * ClkPeriod);
    $display("watchdog expired, the run hung");
    stop_with_failure();
  end

endmodule

/* build.f */
source/red_pkg.sv
source/red_dispatch.sv
source/red_lane.sv
source/red_collect.sv
source/red_offload_unit.sv
verif/red_offload_sva.sv
verif/red_tb_clk.sv
verif/red_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the offload reduction testbench with Verilator and run it.
# A nonzero exit status means the build or the simulation failed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module red_tb \
  --Mdir obj_dir -o red_tb_sim \
  -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/red_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
